// ==== design/tetris_pkg.sv ====
package tetris_pkg;

    // Playfield, rows 0 and 1 are the hidden spawn area
    localparam int FIELD_COLS   = 10;
    localparam int FIELD_ROWS   = 22;
    localparam int FIELD_HIDDEN = 2;

    // Cell codes 0 to 6 are the pieces I J L O S T Z
    localparam int                CELL_W     = 3;
    localparam logic [CELL_W-1:0] CELL_EMPTY = 3'd7;

    // Flat field vector, cell (r,c) at bit (r*FIELD_COLS+c)*CELL_W
    localparam int FIELD_BITS = FIELD_ROWS * FIELD_COLS * CELL_W;

    // Shape mask is row-major with bit row*4+col
    localparam int SHAPE_N = 4;
    localparam int SHAPE_W = SHAPE_N * SHAPE_N;

    // Level bar colour thresholds
    localparam int LEVEL_W    = 4;
    localparam int LEVEL_MID  = 5;
    localparam int LEVEL_HIGH = 10;

    localparam int SCORE_W      = 32;
    localparam int SCORE_DIGITS = 8;

endpackage

// ==== design/video_pkg.sv ====
package video_pkg;

    localparam int SCREEN_W = 1280;
    localparam int SCREEN_H = 800;

    // Field box, centred on the screen
    localparam int BLOCK   = 32;
    localparam int GRID_W  = 320;
    localparam int GRID_H  = 640;
    localparam int GRID_X0 = (SCREEN_W - GRID_W) / 2;
    localparam int GRID_Y0 = (SCREEN_H - GRID_H) / 2;
    localparam int BORDER  = 4;

    // Side panel: next piece, score and level boxes
    localparam int SIDE_X0    = GRID_X0 + GRID_W + 50;
    localparam int NEXT_Y0    = GRID_Y0;
    localparam int SCORE_Y0   = NEXT_Y0 + 200;
    localparam int LEVEL_Y0   = SCORE_Y0 + 150;
    localparam int NEXT_BOX   = 150;
    localparam int SIDE_BOX_W = 200;
    localparam int SIDE_BOX_H = 100;
    localparam int LABEL_H    = 20;
    localparam int PREVIEW_DX = 20;
    localparam int PREVIEW_DY = 40;
    localparam int TEXT_DY    = 40;
    localparam int BAR_H      = 20;
    localparam int BAR_STEP   = 10;

    // 3x5 font scaled by 4, one digit every 16 px
    localparam int GLYPH_SCALE = 4;
    localparam int GLYPH_PITCH = 16;

    localparam int HEART_SIZE = 10;
    localparam int HEART_BIT  = 25;

    // Index 0 is empty, index code+1 is a piece
    localparam logic [11:0] COLOR_MAP [0:7] = '{
        12'h000, 12'hF00, 12'h0F0, 12'h00F, 12'hFF0, 12'hF0F, 12'h0FF, 12'hFA0
    };

    localparam logic [11:0] COL_BLACK       = 12'h000;
    localparam logic [11:0] COL_WHITE       = 12'hFFF;
    localparam logic [11:0] COL_BORDER      = 12'hFFF;
    localparam logic [11:0] COL_GRIDLINE    = 12'h222;
    localparam logic [11:0] COL_GHOST       = 12'h444;
    localparam logic [11:0] COL_OVER        = 12'h666;
    localparam logic [11:0] COL_NEXT_LABEL  = 12'hFFF;
    localparam logic [11:0] COL_SCORE_LABEL = 12'hFF0;
    localparam logic [11:0] COL_LEVEL_LABEL = 12'h0FF;
    localparam logic [11:0] COL_BAR_LOW     = 12'h0F0;
    localparam logic [11:0] COL_BAR_MID     = 12'hFF0;
    localparam logic [11:0] COL_BAR_HIGH    = 12'hF00;

endpackage

// ==== design/field_cell_lookup.sv ====
`timescale 1ns/1ps

module field_cell_lookup (
    input  logic [10:0]                       curr_x,
    input  logic [9:0]                        curr_y,
    input  logic [tetris_pkg::FIELD_BITS-1:0] field,
    input  logic [tetris_pkg::SHAPE_W-1:0]    curr_shape,
    input  logic signed [4:0]                 curr_col,
    input  logic signed [5:0]                 ghost_row,
    output logic                              in_grid,
    output logic                              on_border,
    output logic                              on_gridline,
    output logic [2:0]                        cell_code_idx,
    output logic                              ghost_hit,
    output logic [4:0]                        blk_off_x,
    output logic [4:0]                        blk_off_y
);

    logic [10:0]                    rel_x;
    logic [9:0]                     rel_y;
    logic [10:0]                    out_x;
    logic [9:0]                     out_y;
    logic [3:0]                     grid_col;
    logic [4:0]                     field_row;
    logic [9:0]                     cell_pos;
    logic [tetris_pkg::CELL_W-1:0]  cell_code;
    logic                           cell_empty;
    logic signed [6:0]              shape_row;
    logic signed [5:0]              shape_col;
    logic                           in_shape_box;

    // Pixel relative to the field and to the outer border box
    assign rel_x = curr_x - 11'(video_pkg::GRID_X0);
    assign rel_y = curr_y - 10'(video_pkg::GRID_Y0);
    assign out_x = curr_x - 11'(video_pkg::GRID_X0 - video_pkg::BORDER);
    assign out_y = curr_y - 10'(video_pkg::GRID_Y0 - video_pkg::BORDER);

    assign in_grid   = rel_x < 11'(video_pkg::GRID_W) && rel_y < 10'(video_pkg::GRID_H);
    assign on_border = !in_grid
                       && out_x < 11'(video_pkg::GRID_W + 2 * video_pkg::BORDER)
                       && out_y < 10'(video_pkg::GRID_H + 2 * video_pkg::BORDER);

    assign grid_col  = 4'(rel_x / 11'(video_pkg::BLOCK));
    assign field_row = 5'(rel_y / 10'(video_pkg::BLOCK)) + 5'(tetris_pkg::FIELD_HIDDEN);
    assign blk_off_x = 5'(rel_x % 11'(video_pkg::BLOCK));
    assign blk_off_y = 5'(rel_y % 10'(video_pkg::BLOCK));

    // Dark lines on the first and last pixel of each block
    assign on_gridline = in_grid
                         && (blk_off_x == 5'd0 || blk_off_x == 5'(video_pkg::BLOCK - 1)
                          || blk_off_y == 5'd0 || blk_off_y == 5'(video_pkg::BLOCK - 1));

    assign cell_pos = (10'(field_row) * 10'(tetris_pkg::FIELD_COLS) + 10'(grid_col))
                      * 10'(tetris_pkg::CELL_W);
    assign cell_code  = in_grid ? field[cell_pos +: tetris_pkg::CELL_W] : tetris_pkg::CELL_EMPTY;
    assign cell_empty = cell_code == tetris_pkg::CELL_EMPTY;

    assign cell_code_idx = cell_empty ? 3'd0 : cell_code + 3'd1;

    // Cell position inside the falling piece's 4x4 box at its landing row
    assign shape_row = $signed({2'b00, field_row}) - 7'(ghost_row);
    assign shape_col = $signed({2'b00, grid_col}) - 6'(curr_col);
    assign in_shape_box = shape_row >= 7'sd0 && shape_row < 7'(tetris_pkg::SHAPE_N)
                          && shape_col >= 6'sd0 && shape_col < 6'(tetris_pkg::SHAPE_N);

    assign ghost_hit = in_grid && cell_empty && in_shape_box
                       && curr_shape[{shape_row[1:0], shape_col[1:0]}];

endmodule

// ==== design/next_piece_render.sv ====
`timescale 1ns/1ps

module next_piece_render (
    input  logic [10:0]                    curr_x,
    input  logic [9:0]                     curr_y,
    input  logic [tetris_pkg::SHAPE_W-1:0] next_shape,
    input  logic [2:0]                     next_code,
    output logic                           preview_hit,
    output logic [2:0]                     preview_idx,
    output logic [4:0]                     pre_off_x,
    output logic [4:0]                     pre_off_y
);

    logic [10:0] nx;
    logic [9:0]  ny;
    logic [1:0]  nc;
    logic [1:0]  nr;

    // Piece origin sits inside the preview box, below the label
    assign nx = curr_x - 11'(video_pkg::SIDE_X0 + video_pkg::PREVIEW_DX);
    assign ny = curr_y - 10'(video_pkg::NEXT_Y0 + video_pkg::PREVIEW_DY);

    assign nc = 2'(nx / 11'(video_pkg::BLOCK));
    assign nr = 2'(ny / 10'(video_pkg::BLOCK));
    assign pre_off_x = 5'(nx % 11'(video_pkg::BLOCK));
    assign pre_off_y = 5'(ny % 10'(video_pkg::BLOCK));

    // Left of or above the origin wraps to a large value and misses
    assign preview_hit = nx < 11'(tetris_pkg::SHAPE_N * video_pkg::BLOCK)
                         && ny < 10'(tetris_pkg::SHAPE_N * video_pkg::BLOCK)
                         && next_shape[{nr, nc}];

    assign preview_idx = next_code + 3'd1;

endmodule

// ==== design/score_digits.sv ====
`timescale 1ns/1ps

module score_digits (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [10:0]                    curr_x,
    input  logic [9:0]                     curr_y,
    input  logic [tetris_pkg::SCORE_W-1:0] score,
    output logic                           score_on
);

    logic [tetris_pkg::SCORE_W-1:0]        score_seen;
    logic [tetris_pkg::SCORE_W-1:0]        bin_shift;
    logic [4*tetris_pkg::SCORE_DIGITS-1:0] bcd_work;
    logic [4*tetris_pkg::SCORE_DIGITS-1:0] bcd_adj;
    logic [4*tetris_pkg::SCORE_DIGITS-1:0] bcd_next;
    logic [4*tetris_pkg::SCORE_DIGITS-1:0] digits;
    logic [5:0]                            bit_cnt;
    logic                                  busy;
    logic [10:0]                           sx;
    logic [9:0]                            sy;
    logic [2:0]                            digit_pos;
    logic [3:0]                            digit_val;
    logic [1:0]                            glyph_col;
    logic [2:0]                            glyph_row;
    logic [3:0]                            glyph_bit;
    logic [14:0]                           glyph;

    // 3x5 font, top row in the high bits, left pixel first
    function automatic logic [14:0] glyph_rom(input logic [3:0] d);
        case (d)
            4'd0:    glyph_rom = 15'b111_101_101_101_111;
            4'd1:    glyph_rom = 15'b010_110_010_010_111;
            4'd2:    glyph_rom = 15'b111_001_111_100_111;
            4'd3:    glyph_rom = 15'b111_001_111_001_111;
            4'd4:    glyph_rom = 15'b101_101_111_001_001;
            4'd5:    glyph_rom = 15'b111_100_111_001_111;
            4'd6:    glyph_rom = 15'b111_100_111_101_111;
            4'd7:    glyph_rom = 15'b111_001_001_001_001;
            4'd8:    glyph_rom = 15'b111_101_111_101_111;
            4'd9:    glyph_rom = 15'b111_101_111_001_111;
            default: glyph_rom = 15'b000_000_000_000_000;
        endcase
    endfunction

    // Add 3 to each digit of 5 or more, then shift in the next binary bit
    always_comb begin
        bcd_adj = bcd_work;
        for (int i = 0; i < tetris_pkg::SCORE_DIGITS; i++) begin
            if (bcd_work[4*i +: 4] >= 4'd5) begin
                bcd_adj[4*i +: 4] = bcd_work[4*i +: 4] + 4'd3;
            end
        end
    end

    assign bcd_next = {bcd_adj[4*tetris_pkg::SCORE_DIGITS-2:0], bin_shift[tetris_pkg::SCORE_W-1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            score_seen <= '0;
            digits     <= '0;
            bit_cnt    <= '0;
            busy       <= 1'b0;
        end else if (busy) begin
            bin_shift <= bin_shift << 1;
            bcd_work  <= bcd_next;
            bit_cnt   <= bit_cnt + 6'd1;
            if (bit_cnt == 6'(tetris_pkg::SCORE_W - 1)) begin
                busy   <= 1'b0;
                digits <= bcd_next;
            end
        end else if (score != score_seen) begin
            score_seen <= score;
            bin_shift  <= score;
            bcd_work   <= '0;
            bit_cnt    <= '0;
            busy       <= 1'b1;
        end
    end

    // Digit row, most significant digit at the left edge
    assign sx = curr_x - 11'(video_pkg::SIDE_X0);
    assign sy = curr_y - 10'(video_pkg::SCORE_Y0 + video_pkg::TEXT_DY);

    assign digit_pos = 3'(sx / 11'(video_pkg::GLYPH_PITCH));
    assign glyph_col = 2'((sx % 11'(video_pkg::GLYPH_PITCH)) / 11'(video_pkg::GLYPH_SCALE));
    assign glyph_row = 3'(sy / 10'(video_pkg::GLYPH_SCALE));
    assign digit_val = digits[4*(tetris_pkg::SCORE_DIGITS - 1 - int'(digit_pos)) +: 4];
    assign glyph     = glyph_rom(digit_val);
    assign glyph_bit = 4'd14 - (4'(glyph_row) * 4'd3 + 4'(glyph_col));

    // Columns 12 to 15 of each pitch are the gap between digits
    assign score_on = sx < 11'(tetris_pkg::SCORE_DIGITS * video_pkg::GLYPH_PITCH)
                      && sy < 10'(5 * video_pkg::GLYPH_SCALE)
                      && glyph_col != 2'd3
                      && glyph[glyph_bit];

    // A conversion ends within SCORE_W cycles of its start
    assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> !$past(busy, tetris_pkg::SCORE_W + 1));

endmodule

// ==== design/block_shader.sv ====
`timescale 1ns/1ps

module block_shader (
    input  logic [2:0]  shade_idx,
    input  logic        shade_ghost,
    input  logic        shade_grey,
    input  logic [11:0] sprite_pixel,
    output logic [11:0] shade_rgb
);

    logic [11:0] base;
    logic [3:0]  intensity;

    assign intensity = sprite_pixel[7:4];

    always_comb begin
        if (shade_ghost) begin
            base = video_pkg::COL_GHOST;
        end else if (shade_grey) begin
            base = video_pkg::COL_OVER;
        end else begin
            base = video_pkg::COLOR_MAP[shade_idx];
        end

        // Texture: darker sprite texels halve every channel
        if (intensity != 4'hF) begin
            shade_rgb = {1'b0, base[11:9], 1'b0, base[7:5], 1'b0, base[3:1]};
        end else begin
            shade_rgb = base;
        end
    end

endmodule

// ==== design/tetris_pixel_ctrl.sv ====
`timescale 1ns/1ps

module tetris_pixel_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [10:0]                    curr_x,
    input  logic [9:0]                     curr_y,
    input  logic                           active_area,
    input  logic                           game_over,
    input  logic [tetris_pkg::LEVEL_W-1:0] level,
    input  logic                           in_grid,
    input  logic                           on_border,
    input  logic                           on_gridline,
    input  logic [2:0]                     cell_code_idx,
    input  logic                           ghost_hit,
    input  logic [4:0]                     blk_off_x,
    input  logic [4:0]                     blk_off_y,
    input  logic                           preview_hit,
    input  logic [2:0]                     preview_idx,
    input  logic [4:0]                     pre_off_x,
    input  logic [4:0]                     pre_off_y,
    input  logic                           score_on,
    input  logic [11:0]                    shade_rgb,
    output logic [2:0]                     shade_idx,
    output logic                           shade_ghost,
    output logic                           shade_grey,
    output logic [3:0]                     sprite_addr_x,
    output logic [3:0]                     sprite_addr_y,
    output logic [3:0]                     vga_r,
    output logic [3:0]                     vga_g,
    output logic [3:0]                     vga_b
);

    logic [10:0]                 side_x;
    logic [9:0]                  next_y;
    logic [9:0]                  score_y;
    logic [9:0]                  level_y;
    logic [10:0]                 heart_x;
    logic [9:0]                  heart_y;
    logic                        reg_grid;
    logic                        reg_next;
    logic                        reg_score;
    logic                        reg_level;
    logic                        sel_preview;
    logic                        draw_ghost;
    logic [10:0]                 bar_w;
    logic                        on_bar;
    logic                        on_heart;
    logic [11:0]                 bar_rgb;
    logic [11:0]                 pix;
    logic [video_pkg::HEART_BIT:0] heart_cnt;

    assign side_x  = curr_x - 11'(video_pkg::SIDE_X0);
    assign next_y  = curr_y - 10'(video_pkg::NEXT_Y0);
    assign score_y = curr_y - 10'(video_pkg::SCORE_Y0);
    assign level_y = curr_y - 10'(video_pkg::LEVEL_Y0);

    // Screen regions, the boxes do not overlap
    assign reg_grid  = in_grid || on_border;
    assign reg_next  = side_x < 11'(video_pkg::NEXT_BOX) && next_y < 10'(video_pkg::NEXT_BOX);
    assign reg_score = side_x < 11'(video_pkg::SIDE_BOX_W)
                       && score_y < 10'(video_pkg::SIDE_BOX_H);
    assign reg_level = side_x < 11'(video_pkg::SIDE_BOX_W)
                       && level_y < 10'(video_pkg::SIDE_BOX_H);

    // One shader serves both the preview box and the field
    assign sel_preview   = reg_next && preview_hit;
    assign draw_ghost    = cell_code_idx == 3'd0 && ghost_hit && !game_over;
    assign shade_idx     = sel_preview ? preview_idx : cell_code_idx;
    assign shade_ghost   = !sel_preview && draw_ghost;
    assign shade_grey    = !sel_preview && game_over;
    assign sprite_addr_x = sel_preview ? pre_off_x[4:1] : blk_off_x[4:1];
    assign sprite_addr_y = sel_preview ? pre_off_y[4:1] : blk_off_y[4:1];

    // Level bar grows 10 px per level
    assign bar_w  = 11'((int'(level) + 1) * video_pkg::BAR_STEP);
    assign on_bar = side_x < bar_w && level_y >= 10'(video_pkg::TEXT_DY)
                    && level_y < 10'(video_pkg::TEXT_DY + video_pkg::BAR_H);

    always_comb begin
        if (int'(level) < tetris_pkg::LEVEL_MID) begin
            bar_rgb = video_pkg::COL_BAR_LOW;
        end else if (int'(level) < tetris_pkg::LEVEL_HIGH) begin
            bar_rgb = video_pkg::COL_BAR_MID;
        end else begin
            bar_rgb = video_pkg::COL_BAR_HIGH;
        end
    end

    // Heartbeat square in the field's bottom-right corner
    assign heart_x = curr_x - 11'(video_pkg::GRID_X0 + video_pkg::GRID_W - video_pkg::HEART_SIZE);
    assign heart_y = curr_y - 10'(video_pkg::GRID_Y0 + video_pkg::GRID_H - video_pkg::HEART_SIZE);
    assign on_heart = heart_x < 11'(video_pkg::HEART_SIZE) && heart_y < 10'(video_pkg::HEART_SIZE);

    always_comb begin
        pix = video_pkg::COL_BLACK;
        if (reg_grid) begin
            // Border, then locked block, then ghost, then grid line
            if (on_border) begin
                pix = video_pkg::COL_BORDER;
            end else if (cell_code_idx != 3'd0 || draw_ghost) begin
                pix = shade_rgb;
            end else if (on_gridline) begin
                pix = video_pkg::COL_GRIDLINE;
            end
        end else if (reg_next) begin
            if (next_y < 10'(video_pkg::LABEL_H)) begin
                pix = video_pkg::COL_NEXT_LABEL;
            end else if (preview_hit) begin
                pix = shade_rgb;
            end
        end else if (reg_score) begin
            if (score_y < 10'(video_pkg::LABEL_H)) begin
                pix = video_pkg::COL_SCORE_LABEL;
            end else if (score_on) begin
                pix = video_pkg::COL_WHITE;
            end
        end else if (reg_level) begin
            if (level_y < 10'(video_pkg::LABEL_H)) begin
                pix = video_pkg::COL_LEVEL_LABEL;
            end else if (on_bar) begin
                pix = bar_rgb;
            end
        end
        if (on_heart && game_over && heart_cnt[video_pkg::HEART_BIT]) begin
            pix = video_pkg::COL_WHITE;
        end
        if (!active_area) begin
            pix = video_pkg::COL_BLACK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            heart_cnt <= '0;
            vga_r     <= 4'h0;
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            heart_cnt <= heart_cnt + 1'b1;
            vga_r     <= pix[11:8];
            vga_g     <= pix[7:4];
            vga_b     <= pix[3:0];
        end
    end

    // Field and side panel geometry never claim the same pixel
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({reg_grid, reg_next, reg_score, reg_level}));

endmodule

// ==== design/tetris_display.sv ====
`timescale 1ns/1ps

module tetris_display (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [10:0]                       curr_x,
    input  logic [9:0]                        curr_y,
    input  logic                              active_area,
    input  logic [tetris_pkg::FIELD_BITS-1:0] field,
    input  logic [tetris_pkg::SCORE_W-1:0]    score,
    input  logic                              game_over,
    input  logic [tetris_pkg::LEVEL_W-1:0]    level,
    input  logic [tetris_pkg::SHAPE_W-1:0]    curr_shape,
    input  logic signed [4:0]                 curr_col,
    input  logic signed [5:0]                 ghost_row,
    input  logic [tetris_pkg::SHAPE_W-1:0]    next_shape,
    input  logic [2:0]                        next_code,
    output logic [3:0]                        sprite_addr_x,
    output logic [3:0]                        sprite_addr_y,
    input  logic [11:0]                       sprite_pixel,
    output logic [3:0]                        vga_r,
    output logic [3:0]                        vga_g,
    output logic [3:0]                        vga_b
);

    // Field lookup
    logic       in_grid;
    logic       on_border;
    logic       on_gridline;
    logic [2:0] cell_code_idx;
    logic       ghost_hit;
    logic [4:0] blk_off_x;
    logic [4:0] blk_off_y;

    // Preview, score and shader
    logic        preview_hit;
    logic [2:0]  preview_idx;
    logic [4:0]  pre_off_x;
    logic [4:0]  pre_off_y;
    logic        score_on;
    logic [2:0]  shade_idx;
    logic        shade_ghost;
    logic        shade_grey;
    logic [11:0] shade_rgb;

    // Port names match the nets above one to one
    field_cell_lookup u_field (.*);
    next_piece_render u_next (.*);
    score_digits      u_score (.*);
    block_shader      u_shader (.*);
    tetris_pixel_ctrl u_ctrl (.*);

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for the first 3 rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tb/display_checker.sv ====
`timescale 1ns/1ps

module display_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        check_en,
    input  logic [15:0] test_num,
    input  logic [10:0] probe_x,
    input  logic [9:0]  probe_y,
    input  logic [11:0] exp_rgb,
    input  logic [3:0]  vga_r,
    input  logic [3:0]  vga_g,
    input  logic [3:0]  vga_b,
    input  logic [3:0]  sprite_addr_x,
    input  logic [3:0]  sprite_addr_y,
    output int          pass_cnt,
    output int          fail_cnt
);

    logic [11:0] got_rgb;
    logic        in_field;
    logic [3:0]  exp_addr_x;
    logic [3:0]  exp_addr_y;
    logic        addr_ok;

    assign got_rgb = {vga_r, vga_g, vga_b};

    // Field pixels read the texel at half their offset in the block
    assign in_field   = probe_x >= 11'(video_pkg::GRID_X0)
                        && probe_x < 11'(video_pkg::GRID_X0 + video_pkg::GRID_W)
                        && probe_y >= 10'(video_pkg::GRID_Y0)
                        && probe_y < 10'(video_pkg::GRID_Y0 + video_pkg::GRID_H);
    assign exp_addr_x = 4'(((int'(probe_x) - video_pkg::GRID_X0) % video_pkg::BLOCK) / 2);
    assign exp_addr_y = 4'(((int'(probe_y) - video_pkg::GRID_Y0) % video_pkg::BLOCK) / 2);
    assign addr_ok    = !in_field
                        || (sprite_addr_x === exp_addr_x && sprite_addr_y === exp_addr_y);

    // The strobe arrives one edge after the pixel was registered
    // Sprite address still follows the probed pixel on the inputs
    always @(posedge clk) begin
        if (rst) begin
            pass_cnt <= 0;
            fail_cnt <= 0;
        end else if (check_en) begin
            if (got_rgb === exp_rgb && addr_ok) begin
                pass_cnt <= pass_cnt + 1;
                $display("test %0d pixel (%0d,%0d): %03h as expected",
                         test_num, probe_x, probe_y, got_rgb);
            end else if (got_rgb !== exp_rgb) begin
                fail_cnt <= fail_cnt + 1;
                $display("error at %0t ns: test %0d pixel (%0d,%0d) gave %03h, expected %03h",
                         $time, test_num, probe_x, probe_y, got_rgb, exp_rgb);
            end else begin
                fail_cnt <= fail_cnt + 1;
                $display("error at %0t ns: test %0d pixel (%0d,%0d) sprite (%0d,%0d), expected (%0d,%0d)",
                         $time, test_num, probe_x, probe_y, sprite_addr_x, sprite_addr_y,
                         exp_addr_x, exp_addr_y);
            end
        end
    end

endmodule

// ==== tb/tetris_display_tb.sv ====
`timescale 1ns/1ps

module tetris_display_tb;

    typedef struct packed {
        int          x;
        int          y;
        logic        act;
        logic        go;
        int          lvl;
        int          score;
        int          hold;
        logic [11:0] rgb;
    } stim_t;

    localparam int          RANDOM_PROBES = 16;
    localparam logic [15:0] O_MASK        = 16'h0066;
    localparam logic [15:0] T_MASK        = 16'h0027;

    logic                              clk;
    logic                              rst;
    logic [10:0]                       curr_x;
    logic [9:0]                        curr_y;
    logic                              active_area;
    logic [tetris_pkg::FIELD_BITS-1:0] field;
    logic [tetris_pkg::SCORE_W-1:0]    score;
    logic                              game_over;
    logic [tetris_pkg::LEVEL_W-1:0]    level;
    logic [tetris_pkg::SHAPE_W-1:0]    curr_shape;
    logic signed [4:0]                 curr_col;
    logic signed [5:0]                 ghost_row;
    logic [tetris_pkg::SHAPE_W-1:0]    next_shape;
    logic [2:0]                        next_code;
    logic [3:0]                        sprite_addr_x;
    logic [3:0]                        sprite_addr_y;
    logic [11:0]                       sprite_pixel;
    logic [3:0]                        vga_r;
    logic [3:0]                        vga_g;
    logic [3:0]                        vga_b;

    logic        check_en;
    logic [11:0] exp_rgb;
    logic [15:0] test_num;
    int          pass_cnt;
    int          fail_cnt;
    stim_t       stim_q[$];
    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          cycle_limit;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    tetris_display uut (.*);

    display_checker u_check (
        .clk(clk), .rst(rst), .check_en(check_en), .test_num(test_num),
        .probe_x(curr_x), .probe_y(curr_y), .exp_rgb(exp_rgb),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .sprite_addr_x(sprite_addr_x), .sprite_addr_y(sprite_addr_y),
        .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    // Sprite ROM model, texels with address x 0 are dim
    assign sprite_pixel = {4'h0, (sprite_addr_x == 4'd0) ? 4'h7 : 4'hF, 4'h0};

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Empty cell: dark line on the first and last pixel of a block
    function automatic logic [11:0] empty_cell_rgb(input int x, input int y);
        int ox;
        int oy;
        ox = (x - video_pkg::GRID_X0) % video_pkg::BLOCK;
        oy = (y - video_pkg::GRID_Y0) % video_pkg::BLOCK;
        if (ox == 0 || ox == 31 || oy == 0 || oy == 31) begin
            return 12'h222;
        end
        return 12'h000;
    endfunction

    task automatic add_entry(input int x, input int y, input logic act, input logic go,
                             input int lvl, input int scr, input int hold,
                             input logic [11:0] rgb);
        stim_t e;
        e.x     = x;
        e.y     = y;
        e.act   = act;
        e.go    = go;
        e.lvl   = lvl;
        e.score = scr;
        e.hold  = hold;
        e.rgb   = rgb;
        stim_q.push_back(e);
    endtask

    initial begin
        int px;
        int py;
        curr_x      = '0;
        curr_y      = '0;
        active_area = 1'b0;
        game_over   = 1'b0;
        level       = '0;
        score       = '0;
        curr_shape  = O_MASK;
        curr_col    = 5'sd4;
        ghost_row   = 6'sd18;
        next_shape  = T_MASK;
        next_code   = 3'd5;
        check_en    = 1'b0;
        exp_rgb     = '0;
        test_num    = '0;
        field       = {(tetris_pkg::FIELD_ROWS * tetris_pkg::FIELD_COLS){3'd7}};
        // Bottom row: I at column 0, Z at column 9
        field[(21 * 10 + 0) * 3 +: 3] = 3'd0;
        field[(21 * 10 + 9) * 3 +: 3] = 3'd6;

        // Border, grid line, empty cell, blanking
        add_entry(478, 100, 1, 0, 2, 0, 1, 12'hFFF);
        add_entry(480, 80, 1, 0, 2, 0, 1, 12'h222);
        add_entry(500, 100, 1, 0, 2, 0, 1, 12'h000);
        add_entry(478, 100, 0, 0, 2, 0, 1, 12'h000);
        // Locked blocks, texture and game over grey
        add_entry(480, 700, 1, 0, 2, 0, 1, 12'h700);
        add_entry(482, 700, 1, 0, 2, 0, 1, 12'hF00);
        add_entry(770, 700, 1, 0, 2, 0, 1, 12'hFA0);
        add_entry(768, 700, 1, 0, 2, 0, 1, 12'h750);
        add_entry(482, 700, 1, 1, 2, 0, 1, 12'h666);
        add_entry(480, 700, 1, 1, 2, 0, 1, 12'h333);
        // Ghost of the O piece
        add_entry(650, 600, 1, 0, 2, 0, 1, 12'h444);
        add_entry(641, 600, 1, 0, 2, 0, 1, 12'h222);
        add_entry(630, 600, 1, 0, 2, 0, 1, 12'h000);
        add_entry(650, 600, 1, 1, 2, 0, 1, 12'h000);
        // Next piece preview
        add_entry(880, 130, 1, 0, 2, 0, 1, 12'h0FF);
        add_entry(870, 130, 1, 0, 2, 0, 1, 12'h077);
        add_entry(880, 170, 1, 0, 2, 0, 1, 12'h000);
        add_entry(900, 85, 1, 0, 2, 0, 1, 12'hFFF);
        // Score box at score 0
        add_entry(860, 285, 1, 0, 2, 0, 1, 12'hFF0);
        add_entry(851, 321, 1, 0, 2, 0, 1, 12'hFFF);
        add_entry(855, 328, 1, 0, 2, 0, 1, 12'h000);
        add_entry(902, 328, 1, 0, 2, 0, 1, 12'h000);
        add_entry(863, 321, 1, 0, 2, 0, 1, 12'h000);
        // Level bar, label and colour steps
        add_entry(860, 435, 1, 0, 2, 0, 1, 12'h0FF);
        add_entry(870, 475, 1, 0, 2, 0, 1, 12'h0F0);
        add_entry(880, 475, 1, 0, 2, 0, 1, 12'h000);
        add_entry(920, 475, 1, 0, 7, 0, 1, 12'hFF0);
        add_entry(930, 475, 1, 0, 7, 0, 1, 12'h000);
        add_entry(970, 475, 1, 0, 12, 0, 1, 12'hF00);
        add_entry(980, 475, 1, 0, 12, 0, 1, 12'h000);
        // Heartbeat corner stays off, the grey block shows
        add_entry(795, 715, 1, 1, 2, 0, 1, 12'h666);
        // Score 90210 shown as 00090210 once the conversion ends
        add_entry(902, 328, 1, 0, 2, 90210, 40, 12'hFFF);
        add_entry(855, 328, 1, 0, 2, 90210, 1, 12'h000);
        add_entry(851, 321, 1, 0, 2, 90210, 1, 12'hFFF);
        add_entry(946, 321, 1, 0, 2, 90210, 1, 12'h000);
        add_entry(950, 321, 1, 0, 2, 90210, 1, 12'hFFF);
        add_entry(930, 332, 1, 0, 2, 90210, 1, 12'hFFF);
        add_entry(938, 332, 1, 0, 2, 90210, 1, 12'h000);

        // Random pixels in the empty upper 16 rows of the field
        rng = 32'd94;
        for (int i = 0; i < RANDOM_PROBES; i++) begin
            rng = xorshift32(rng);
            px  = video_pkg::GRID_X0 + int'(rng % 32'd320);
            rng = xorshift32(rng);
            py  = video_pkg::GRID_Y0 + int'(rng % 32'd512);
            add_entry(px, py, 1, 0, 2, 90210, 1, empty_cell_rgb(px, py));
        end

        cycle_limit = 3 + 100 + 3;
        foreach (stim_q[i]) begin
            cycle_limit = cycle_limit + stim_q[i].hold + 1;
        end

        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end

        foreach (stim_q[i]) begin
            curr_x      <= 11'(stim_q[i].x);
            curr_y      <= 10'(stim_q[i].y);
            active_area <= stim_q[i].act;
            game_over   <= stim_q[i].go;
            level       <= 4'(stim_q[i].lvl);
            score       <= 32'(stim_q[i].score);
            check_en    <= 1'b0;
            repeat (stim_q[i].hold) @(posedge clk);
            exp_rgb  <= stim_q[i].rgb;
            test_num <= 16'(i);
            check_en <= 1'b1;
            @(posedge clk);
        end
        check_en <= 1'b0;
        repeat (2) @(posedge clk);

        $display("Tests run: %0d, passed: %0d, failed: %0d", stim_q.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == stim_q.size()) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Run length bound from the table's hold times
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

// ==== tetris_display.f ====
design/tetris_pkg.sv
design/video_pkg.sv
design/field_cell_lookup.sv
design/next_piece_render.sv
design/score_digits.sv
design/block_shader.sv
design/tetris_pixel_ctrl.sv
design/tetris_display.sv
tb/tb_clock.sv
tb/display_checker.sv
tb/tetris_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tetris_display_tb \
    -f tetris_display.f --Mdir obj_dir -o tetris_display_sim \
    && ./obj_dir/tetris_display_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
